// File: source/revo_pkg.sv
`default_nettype none

package revo_pkg;

	// bits per serializer word
	localparam int word_bits = 8;

	// one serializer word, bit 7 leaves first
	typedef logic [word_bits-1:0] word_t;

	// revolution channel on a marker cycle
	localparam word_t marker_word = 8'b1111_1111;

	// revolution channel on every other cycle
	localparam word_t idle_word = 8'b0000_0000;

	// quad-bunch words in one turn
	localparam int default_words_per_revo = 1280;

	// word clock cycles of internal reset after power-up or a reset pulse
	localparam int default_reset_hold = 1024;

endpackage

`default_nettype wire

// File: source/reset_sequencer.sv
`default_nettype none

module reset_sequencer #(
	parameter int reset_hold = revo_pkg::default_reset_hold
) (
	input logic clock50,
	input logic reset,
	output logic run_reset
);

	localparam int hold_bits = $clog2(reset_hold + 1);
	localparam logic [hold_bits-1:0] hold_load = hold_bits'(reset_hold);

	// starts loaded, so configuration gives a full hold as well
	logic [hold_bits-1:0] hold_count = hold_load;

	// reload on every cycle reset is seen, then run down to zero
	always_ff @(posedge clock50) begin
		if (reset) begin
			hold_count <= hold_load;
		end else if (hold_count != '0) begin
			hold_count <= hold_count - 1'b1;
		end
	end

	// held until the count is spent
	assign run_reset = (hold_count != '0);

endmodule

`default_nettype wire

// File: source/revo_marker_generator.sv
`default_nettype none

module revo_marker_generator #(
	parameter int words_per_revo = revo_pkg::default_words_per_revo
) (
	input logic clock50,
	input logic run_reset,
	output logic marker_pulse,
	output revo_pkg::word_t revo_word
);

	import revo_pkg::*;

	localparam int count_bits = $clog2(words_per_revo + 1);
	localparam logic [count_bits-1:0] reload_value = count_bits'(words_per_revo - 1);

	// quad-bunch words left in this turn
	logic [count_bits-1:0] quad_bunch_count;
	logic turn_done;

	assign turn_done = (quad_bunch_count == '0);

	always_ff @(posedge clock50) begin
		if (run_reset) begin
			quad_bunch_count <= reload_value;
		end else if (turn_done) begin
			quad_bunch_count <= reload_value;
		end else begin
			quad_bunch_count <= quad_bunch_count - 1'b1;
		end
	end

	// marker word and pulse land one cycle after the count hits zero
	always_ff @(posedge clock50) begin
		if (run_reset) begin
			marker_pulse <= 1'b0;
			revo_word <= idle_word;
		end else if (turn_done) begin
			marker_pulse <= 1'b1;
			revo_word <= marker_word;
		end else begin
			marker_pulse <= 1'b0;
			revo_word <= idle_word;
		end
	end

endmodule

`default_nettype wire

// File: source/bunch_clock_pattern.sv
`default_nettype none

module bunch_clock_pattern #(
	parameter int clock_half_bits = 1
) (
	input logic clock50,
	input logic run_reset,
	input logic marker_pulse,
	output revo_pkg::word_t clock_word
);

	import revo_pkg::*;

	// one full bunch clock period in serial bits
	localparam int period = 2 * clock_half_bits;
	localparam int phase_bits = $clog2(period);
	localparam logic [phase_bits-1:0] last_phase = phase_bits'(period - 1);

	// bit phase of the first bit of the next word
	logic [phase_bits-1:0] phase_count;
	logic [phase_bits-1:0] phase_now;
	logic [phase_bits-1:0] phase_next;
	word_t pattern;

	// a marker forces phase 0 so the clock realigns every turn
	assign phase_now = marker_pulse ? '0 : phase_count;

	always_comb begin
		logic [phase_bits-1:0] bit_phase;
		bit_phase = phase_now;
		// msb first, high for the first half of the period
		for (int i = word_bits - 1; i >= 0; i--) begin
			pattern[i] = (bit_phase < phase_bits'(clock_half_bits));
			if (bit_phase == last_phase) begin
				bit_phase = '0;
			end else begin
				bit_phase = bit_phase + 1'b1;
			end
		end
		// after a full word this is the phase of the following word
		phase_next = bit_phase;
	end

	always_ff @(posedge clock50) begin
		if (run_reset) begin
			phase_count <= '0;
		end else begin
			phase_count <= phase_next;
		end
	end

	always_ff @(posedge clock50) begin
		if (run_reset) begin
			clock_word <= '0;
		end else begin
			clock_word <= pattern;
		end
	end

endmodule

`default_nettype wire

// File: source/word_delay_line.sv
`default_nettype none

module word_delay_line #(
	parameter type payload_t = revo_pkg::word_t,
	parameter int depth = 0
) (
	input logic clock50,
	input logic run_reset,
	input payload_t data_in,
	output payload_t data_out
);

	generate
		if (depth == 0) begin : gen_pass
			// no alignment needed
			assign data_out = data_in;
		end else begin : gen_shift
			payload_t stages [depth];

			always_ff @(posedge clock50) begin
				if (run_reset) begin
					for (int k = 0; k < depth; k++) begin
						stages[k] <= '0;
					end
				end else begin
					stages[0] <= data_in;
					for (int k = 1; k < depth; k++) begin
						stages[k] <= stages[k-1];
					end
				end
			end

			// oldest stage is the output
			assign data_out = stages[depth-1];
		end
	endgenerate

endmodule

`default_nettype wire

// File: source/status_display.sv
`default_nettype none

module status_display #(
	parameter int stretch_cycles = 5
) (
	input logic clock50,
	input logic run_reset,
	input logic marker_pulse,
	output logic [7:0] leds
);

	localparam int stretch_bits = $clog2(stretch_cycles + 1);

	// the pulse itself covers the first cycle
	localparam logic [stretch_bits-1:0] stretch_load = stretch_bits'(stretch_cycles - 1);

	logic [stretch_bits-1:0] stretch_count;
	logic marker_visible;
	logic revo_seen;

	// retriggers on every marker
	always_ff @(posedge clock50) begin
		if (run_reset) begin
			stretch_count <= '0;
		end else if (marker_pulse) begin
			stretch_count <= stretch_load;
		end else if (stretch_count != '0) begin
			stretch_count <= stretch_count - 1'b1;
		end
	end

	assign marker_visible = marker_pulse | (stretch_count != '0);

	// sticky until the next reset
	always_ff @(posedge clock50) begin
		if (run_reset) begin
			revo_seen <= 1'b0;
		end else if (marker_pulse) begin
			revo_seen <= 1'b1;
		end
	end

	assign leds[7:6] = 2'b00;
	assign leds[5] = run_reset;
	assign leds[4] = marker_visible;
	assign leds[3] = revo_seen | marker_pulse;
	assign leds[2:0] = 3'b000;

endmodule

`default_nettype wire

// File: source/revo_clock_top.sv
`default_nettype none

module revo_clock_top #(
	parameter int words_per_revo = revo_pkg::default_words_per_revo,
	parameter int reset_hold = revo_pkg::default_reset_hold,
	parameter int clock_half_bits = 1,
	parameter int align_delay = 0,
	parameter int stretch_cycles = 5000000
) (
	input logic clock50,
	input logic reset,
	output revo_pkg::word_t clock_word,
	output revo_pkg::word_t revo_word,
	output logic lemo,
	output logic [7:0] leds
);

	import revo_pkg::*;

	logic run_reset;
	logic marker_pulse;
	word_t clock_word_raw;
	word_t revo_word_raw;

	reset_sequencer #(
		.reset_hold(reset_hold)
	) reset_sequencer_inst (
		.clock50(clock50),
		.reset(reset),
		.run_reset(run_reset)
	);

	revo_marker_generator #(
		.words_per_revo(words_per_revo)
	) revo_marker_generator_inst (
		.clock50(clock50),
		.run_reset(run_reset),
		.marker_pulse(marker_pulse),
		.revo_word(revo_word_raw)
	);

	// divided clock, phase locked to the marker
	bunch_clock_pattern #(
		.clock_half_bits(clock_half_bits)
	) bunch_clock_pattern_inst (
		.clock50(clock50),
		.run_reset(run_reset),
		.marker_pulse(marker_pulse),
		.clock_word(clock_word_raw)
	);

	// same depth on all three keeps the outputs lined up
	word_delay_line #(
		.payload_t(word_t),
		.depth(align_delay)
	) clock_delay_inst (
		.clock50(clock50),
		.run_reset(run_reset),
		.data_in(clock_word_raw),
		.data_out(clock_word)
	);

	word_delay_line #(
		.payload_t(word_t),
		.depth(align_delay)
	) revo_delay_inst (
		.clock50(clock50),
		.run_reset(run_reset),
		.data_in(revo_word_raw),
		.data_out(revo_word)
	);

	word_delay_line #(
		.payload_t(logic),
		.depth(align_delay)
	) lemo_delay_inst (
		.clock50(clock50),
		.run_reset(run_reset),
		.data_in(marker_pulse),
		.data_out(lemo)
	);

	// led stretch works on the undelayed pulse
	status_display #(
		.stretch_cycles(stretch_cycles)
	) status_display_inst (
		.clock50(clock50),
		.run_reset(run_reset),
		.marker_pulse(marker_pulse),
		.leds(leds)
	);

endmodule

`default_nettype wire

// File: tb/revo_clock_tb.sv
`default_nettype none

module revo_clock_tb;

	import revo_pkg::*;

	localparam int words_per_revo = 20;
	localparam int reset_hold = 16;
	localparam int clock_half_bits = 3;
	localparam int align_delay = 2;
	localparam int stretch_cycles = 5;
	localparam int wait_limit = 100;
	localparam int row_count = 9;

	// reset pulse cycles (0 = none), run cycles (0 = random), lemo count (-1 = from model)
	localparam int pulse_table [row_count] = '{10, 0, 0, 3, 0, 0, 3, 0, 3};
	localparam int run_table [row_count] = '{45, 30, 0, 10, 70, 0, 5, 0, 60};
	localparam int lemo_table [row_count] = '{3, 1, -1, 1, 4, -1, 1, -1, 4};

	logic clock50;
	logic reset;
	word_t clock_word;
	word_t revo_word;
	logic lemo;
	logic [7:0] leds;

	integer seed;
	int error_count;
	int check_count;
	logic reset_driven;
	logic timed_out;

	// reference model state
	int ref_hold;
	int ref_revo_pos;
	int ref_word_index;
	int ref_since_marker;
	logic ref_marker;
	logic ref_seen;
	logic [7:0] ref_clock_raw;
	logic [7:0] ref_revo_raw;
	logic [7:0] ref_clock_dly [align_delay];
	logic [7:0] ref_revo_dly [align_delay];
	logic ref_lemo_dly [align_delay];

	revo_clock_top #(
		.words_per_revo(words_per_revo),
		.reset_hold(reset_hold),
		.clock_half_bits(clock_half_bits),
		.align_delay(align_delay),
		.stretch_cycles(stretch_cycles)
	) DUT (
		.clock50(clock50),
		.reset(reset),
		.clock_word(clock_word),
		.revo_word(revo_word),
		.lemo(lemo),
		.leds(leds)
	);

	initial begin
		clock50 = 1'b0;
		forever #4 clock50 = ~clock50;
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %0s: got 0x%h, expected 0x%h at %0t", name, got, expected,
				$time);
		end
	endtask

	task automatic report_timeout(input string what);
		error_count++;
		timed_out = 1'b1;
		$display("timeout while waiting for %0s", what);
	endtask

	// square wave with the serial bit index counted from the last phase restart
	function automatic logic [7:0] pattern_word(input int first_bit);
		logic [7:0] word;
		for (int j = 0; j < 8; j++) begin
			word[7-j] = ((first_bit + j) % (2 * clock_half_bits)) < clock_half_bits;
		end
		return word;
	endfunction

	// advance the model by one clock edge with the reset level the DUT sees
	task automatic model_step(input logic reset_seen);
		logic run_pre;
		logic marker_pre;
		logic [7:0] clock_pre;
		logic [7:0] revo_pre;
		run_pre = (ref_hold != 0);
		marker_pre = ref_marker;
		clock_pre = ref_clock_raw;
		revo_pre = ref_revo_raw;

		if (reset_seen) begin
			ref_hold = reset_hold;
		end else if (ref_hold > 0) begin
			ref_hold--;
		end

		if (run_pre) begin
			for (int k = 0; k < align_delay; k++) begin
				ref_clock_dly[k] = '0;
				ref_revo_dly[k] = '0;
				ref_lemo_dly[k] = 1'b0;
			end
		end else begin
			for (int k = align_delay - 1; k > 0; k--) begin
				ref_clock_dly[k] = ref_clock_dly[k-1];
				ref_revo_dly[k] = ref_revo_dly[k-1];
				ref_lemo_dly[k] = ref_lemo_dly[k-1];
			end
			ref_clock_dly[0] = clock_pre;
			ref_revo_dly[0] = revo_pre;
			ref_lemo_dly[0] = marker_pre;
		end

		// marker on every whole revolution since release
		ref_revo_pos = run_pre ? 0 : ref_revo_pos + 1;
		ref_marker = (ref_revo_pos > 0) && (ref_revo_pos % words_per_revo == 0);
		ref_revo_raw = ref_marker ? marker_word : idle_word;

		if (run_pre) begin
			ref_clock_raw = '0;
			ref_word_index = 0;
		end else begin
			if (marker_pre) begin
				ref_word_index = 0;
			end
			ref_clock_raw = pattern_word(ref_word_index * 8);
			ref_word_index++;
		end

		if (run_pre) begin
			ref_since_marker = stretch_cycles;
			ref_seen = 1'b0;
		end else if (marker_pre) begin
			ref_since_marker = 1;
			ref_seen = 1'b1;
		end else if (ref_since_marker < stretch_cycles) begin
			ref_since_marker++;
		end
	endtask

	task automatic compare_outputs();
		logic [7:0] expected_leds;
		expected_leds = 8'h00;
		expected_leds[5] = (ref_hold != 0);
		expected_leds[4] = ref_marker || (ref_since_marker < stretch_cycles);
		expected_leds[3] = ref_seen || ref_marker;
		check_value("clock_word", clock_word, ref_clock_dly[align_delay-1]);
		check_value("revo_word", revo_word, ref_revo_dly[align_delay-1]);
		check_value("lemo", lemo, ref_lemo_dly[align_delay-1]);
		check_value("leds", leds, expected_leds);
	endtask

	// drive on the rising edge and compare at the falling edge
	task automatic step(input logic reset_value);
		@(posedge clock50);
		model_step(reset_driven);
		reset <= reset_value;
		reset_driven = reset_value;
		@(negedge clock50);
		compare_outputs();
	endtask

	initial begin
		int run_length;
		int waited;
		int lemo_seen;
		int lemo_model;
		int expected_lemo;
		int row_errors;

		reset = 1'b1;
		reset_driven = 1'b1;
		timed_out = 1'b0;
		seed = 80081;
		error_count = 0;
		check_count = 0;
		ref_hold = reset_hold;
		ref_revo_pos = 0;
		ref_word_index = 0;
		ref_since_marker = stretch_cycles;
		ref_marker = 1'b0;
		ref_seen = 1'b0;
		ref_clock_raw = '0;
		ref_revo_raw = '0;
		for (int k = 0; k < align_delay; k++) begin
			ref_clock_dly[k] = '0;
			ref_revo_dly[k] = '0;
			ref_lemo_dly[k] = 1'b0;
		end

		for (int row = 0; row < row_count && !timed_out; row++) begin
			row_errors = error_count;
			lemo_seen = 0;
			lemo_model = 0;
			run_length = run_table[row];
			if (run_length == 0) begin
				run_length = 5 + ({$random(seed)} % 66);
			end

			if (pulse_table[row] > 0) begin
				repeat (pulse_table[row]) step(1'b1);
				// the first step still sees reset high
				step(1'b0);
				waited = 1;
				while (leds[5] !== 1'b0 && waited < wait_limit) begin
					step(1'b0);
					waited++;
				end
				if (leds[5] !== 1'b0) begin
					report_timeout("reset release");
				end else begin
					check_value("release_cycles", waited, reset_hold + 1);
					waited = 0;
					do begin
						step(1'b0);
						waited++;
					end while (lemo !== 1'b1 && waited < wait_limit);
					if (lemo !== 1'b1) begin
						report_timeout("first marker");
					end else begin
						check_value("marker_cycles", waited, words_per_revo + align_delay);
						lemo_seen++;
						lemo_model++;
					end
				end
			end

			if (!timed_out) begin
				for (int c = 0; c < run_length; c++) begin
					step(1'b0);
					if (lemo === 1'b1) begin
						lemo_seen++;
					end
					if (ref_lemo_dly[align_delay-1]) begin
						lemo_model++;
					end
				end

				expected_lemo = (lemo_table[row] < 0) ? lemo_model : lemo_table[row];
				check_value("lemo_count", lemo_seen, expected_lemo);
				$display("row %0d: reset pulse %0d, run %0d cycles, lemo %0d of %0d, errors %0d",
					row, pulse_table[row], run_length, lemo_seen, expected_lemo,
					error_count - row_errors);
			end
		end

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
source/revo_pkg.sv
source/reset_sequencer.sv
source/revo_marker_generator.sv
source/bunch_clock_pattern.sv
source/word_delay_line.sv
source/status_display.sv
source/revo_clock_top.sv
tb/revo_clock_tb.sv

// File: Bender.yml
package:
  name: revo_clock

sources:
  - source/revo_pkg.sv
  - source/reset_sequencer.sv
  - source/revo_marker_generator.sv
  - source/bunch_clock_pattern.sv
  - source/word_delay_line.sv
  - source/status_display.sv
  - source/revo_clock_top.sv
  - target: simulation
    files:
      - tb/revo_clock_tb.sv
